// ==== rtl/bwt_pkg.sv ====
package bwt_pkg;

	// ------------------------------------------------------------------
	// symbols and positions
	// ------------------------------------------------------------------
	typedef logic [1:0]  sym_t;      // A=0 C=1 G=2 T=3
	typedef logic [63:0] bwt_idx_t;  // position in the bwt

	localparam int NUM_SYMS = 4;

	// ------------------------------------------------------------------
	// occurrence table layout
	// ------------------------------------------------------------------
	localparam int OCC_BLOCK     = 128;                   // positions per block
	localparam int OCC_SHIFT     = $clog2(OCC_BLOCK);     // block address shift
	localparam int OCC_WORD_SYMS = 32;                    // symbols per count word
	localparam int OCC_WORDS     = OCC_BLOCK / OCC_WORD_SYMS;

	// cumulative counts per symbol, entry c at 64-bit slot c
	typedef bwt_idx_t [NUM_SYMS-1:0] l2_table_t;

endpackage

// ==== rtl/io_pkg.sv ====
package io_pkg;

	localparam int CL              = 512;  // cache line
	localparam int READ_NUM_WIDTH  = 8;
	localparam int MAX_READ        = 256;  // reads per batch
	localparam int QPTR_WIDTH      = $clog2(MAX_READ);
	localparam int DRAM_ADDR_WIDTH = 32;

	typedef logic [READ_NUM_WIDTH-1:0] read_num_t;
	typedef logic [READ_NUM_WIDTH:0]   batch_size_t;  // up to a full batch
	typedef logic [QPTR_WIDTH-1:0]     qptr_t;
	typedef logic [QPTR_WIDTH:0]       qcnt_t;        // 0 .. MAX_READ

	// ------------------------------------------------------------------
	// load line fields
	// ------------------------------------------------------------------
	localparam int LD_NUM_LSB   = 0;
	localparam int LD_SYM_LSB   = 8;
	localparam int LD_K_LSB     = 64;
	localparam int LD_L_LSB     = 128;
	localparam int PARAM_L2_LSB = 0;   // parameter line, L2 entries from here

	// output line fields, rest of the line is zero
	localparam int OUT_NUM_LSB  = 0;
	localparam int OUT_K_LSB    = 64;
	localparam int OUT_L_LSB    = 128;

endpackage

// ==== rtl/task_if.sv ====
`timescale 1ns/1ps

// one read task handed from block to block, no back-pressure
interface task_if
	import bwt_pkg::*, io_pkg::*;
();

	logic      valid;     // one cycle per task
	read_num_t read_num;
	sym_t      sym;       // symbol to extend by
	bwt_idx_t  k;         // interval start
	bwt_idx_t  l;         // interval end

	modport source (
		output valid, read_num, sym, k, l
	);

	// must take a task on every strobe
	modport sink (
		input valid, read_num, sym, k, l
	);

endinterface

// ==== rtl/read_loader.sv ====
`timescale 1ns/1ps

module read_loader
	import bwt_pkg::*, io_pkg::*;
(
	input  logic          clk_32ui_i,
	input  logic          reset_i,
	input  logic          load_valid_i,
	input  logic [CL-1:0] load_data_i,
	input  batch_size_t   batch_size_i,
	task_if.source        task_o,
	output l2_table_t     l2_table_o
);

	logic        param_taken;  // parameter line seen
	batch_size_t read_cnt;     // read lines accepted
	logic        param_accept;
	logic        read_accept;

	// first line is the parameter line, then batch_size reads
	assign param_accept = load_valid_i && !param_taken;
	assign read_accept  = load_valid_i && param_taken && (read_cnt < batch_size_i);

	// ------------------------------------------------------------------
	// batch tracking
	// ------------------------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			param_taken  <= 1'b0;
			read_cnt     <= '0;
			task_o.valid <= 1'b0;
		end else begin
			task_o.valid <= read_accept;  // one cycle behind the line
			if (param_accept)
				param_taken <= 1'b1;
			if (read_accept)
				read_cnt <= read_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// line slicing
	// ------------------------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (param_accept)
			l2_table_o <= load_data_i[PARAM_L2_LSB +: $bits(l2_table_t)];
		if (read_accept) begin
			task_o.read_num <= load_data_i[LD_NUM_LSB +: READ_NUM_WIDTH];
			task_o.sym      <= load_data_i[LD_SYM_LSB +: $bits(sym_t)];
			task_o.k        <= load_data_i[LD_K_LSB +: $bits(bwt_idx_t)];
			task_o.l        <= load_data_i[LD_L_LSB +: $bits(bwt_idx_t)];
		end
	end

	// lines after a complete batch never reach the queue
	a_no_extra_task: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		load_valid_i && param_taken && (read_cnt == batch_size_i) |=> !task_o.valid);

endmodule

// ==== rtl/task_queue.sv ====
`timescale 1ns/1ps

module task_queue
	import bwt_pkg::*, io_pkg::*;
(
	input  logic                       clk_32ui_i,
	input  logic                       reset_i,
	task_if.sink                       task_i,
	output logic                       dram_valid_o,
	output logic [DRAM_ADDR_WIDTH-1:0] addr_k_o,
	output logic [DRAM_ADDR_WIDTH-1:0] addr_l_o,
	input  logic                       dram_get_i,
	task_if.source                     task_o
);

	typedef struct packed {
		read_num_t read_num;
		sym_t      sym;
		bwt_idx_t  k;
		bwt_idx_t  l;
	} entry_t;

	entry_t store [MAX_READ];
	qptr_t  wr_ptr;       // next free slot
	qptr_t  req_ptr;      // next to request
	qptr_t  ret_ptr;      // next to retire
	qcnt_t  n_unreq;      // stored, not yet requested
	qcnt_t  n_outst;      // requested, waiting for DRAM_get
	entry_t push_entry;
	entry_t req_entry;
	logic   req_go;

	assign push_entry = '{read_num: task_i.read_num, sym: task_i.sym, k: task_i.k, l: task_i.l};

	// oldest waiting task, or the one arriving now when nothing waits
	assign req_go    = (n_unreq != '0) || task_i.valid;
	assign req_entry = (n_unreq != '0) ? store[req_ptr] : push_entry;

	always_ff @(posedge clk_32ui_i) begin
		if (task_i.valid)
			store[wr_ptr] <= push_entry;
	end

	// ------------------------------------------------------------------
	// pointers and request strobe
	// ------------------------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			wr_ptr       <= '0;
			req_ptr      <= '0;
			ret_ptr      <= '0;
			n_unreq      <= '0;
			n_outst      <= '0;
			dram_valid_o <= 1'b0;
		end else begin
			dram_valid_o <= req_go;
			if (task_i.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (req_go)
				req_ptr <= req_ptr + 1'b1;
			if (dram_get_i)
				ret_ptr <= ret_ptr + 1'b1;
			n_unreq <= n_unreq + qcnt_t'(task_i.valid) - qcnt_t'(req_go);
			n_outst <= n_outst + qcnt_t'(req_go) - qcnt_t'(dram_get_i);
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (req_go) begin
			addr_k_o <= DRAM_ADDR_WIDTH'(req_entry.k >> OCC_SHIFT);  // block of k
			addr_l_o <= DRAM_ADDR_WIDTH'(req_entry.l >> OCC_SHIFT);
		end
	end

	// responses come back in request order
	assign task_o.valid    = dram_get_i;
	assign task_o.read_num = store[ret_ptr].read_num;
	assign task_o.sym      = store[ret_ptr].sym;
	assign task_o.k        = store[ret_ptr].k;
	assign task_o.l        = store[ret_ptr].l;

	a_get_outstanding: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		dram_get_i |-> (n_outst != '0));

	a_push_room: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		task_i.valid |-> ((n_unreq + n_outst) < MAX_READ));

endmodule

// ==== rtl/bwt_extender.sv ====
`timescale 1ns/1ps

module bwt_extender
	import bwt_pkg::*, io_pkg::*;
(
	input  logic          clk_32ui_i,
	input  logic          reset_i,
	task_if.sink          task_i,
	input  l2_table_t     l2_table_i,
	input  batch_size_t   batch_size_i,
	input  logic [31:0]   cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i,
	input  logic [63:0]   cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i,
	input  logic [31:0]   cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i,
	input  logic [63:0]   cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i,
	output logic          output_request_o,
	input  logic          output_permit_i,
	output logic [CL-1:0] output_data_o,
	output logic          output_valid_o,
	output logic          output_finish_o
);

	typedef logic [NUM_SYMS-1:0][31:0]  base_arr_t;
	typedef logic [OCC_WORDS-1:0][63:0] blk_arr_t;

	typedef struct packed {
		read_num_t read_num;
		bwt_idx_t  k;
		bwt_idx_t  l;
	} result_t;

	base_arr_t   cnt_a, cntl_a;
	blk_arr_t    cnt_b, cntl_b;
	bwt_idx_t    new_k, new_l;
	result_t     res_buf [MAX_READ];
	qptr_t       wr_ptr, rd_ptr;
	qcnt_t       buf_cnt;
	batch_size_t sent_cnt;   // lines sent this batch
	logic        grant;
	logic [CL-1:0] line;

	// count base plus matches of c among the first n symbols of the block
	function automatic bwt_idx_t occ(input logic [31:0] base, input blk_arr_t blk,
	                                 input logic [OCC_SHIFT-1:0] n, input sym_t c);
		logic [OCC_SHIFT:0] hits;
		hits = '0;
		for (int j = 0; j < OCC_BLOCK; j++) begin
			if (j < n && blk[j / OCC_WORD_SYMS][2*(j % OCC_WORD_SYMS) +: 2] == c)
				hits = hits + 1'b1;
		end
		return bwt_idx_t'(base) + bwt_idx_t'(hits);
	endfunction

	assign cnt_a  = {cnt_a3_i, cnt_a2_i, cnt_a1_i, cnt_a0_i};
	assign cnt_b  = {cnt_b3_i, cnt_b2_i, cnt_b1_i, cnt_b0_i};
	assign cntl_a = {cntl_a3_i, cntl_a2_i, cntl_a1_i, cntl_a0_i};
	assign cntl_b = {cntl_b3_i, cntl_b2_i, cntl_b1_i, cntl_b0_i};

	// ------------------------------------------------------------------
	// one-symbol extension
	// ------------------------------------------------------------------
	assign new_k = l2_table_i[task_i.sym] + bwt_idx_t'(1)
		+ occ(cnt_a[task_i.sym], cnt_b, task_i.k[OCC_SHIFT-1:0], task_i.sym);
	assign new_l = l2_table_i[task_i.sym] + bwt_idx_t'(1)
		+ occ(cntl_a[task_i.sym], cntl_b, task_i.l[OCC_SHIFT-1:0], task_i.sym);

	always_ff @(posedge clk_32ui_i) begin
		if (task_i.valid)
			res_buf[wr_ptr] <= '{read_num: task_i.read_num, k: new_k, l: new_l};
	end

	// ------------------------------------------------------------------
	// output exchange
	// ------------------------------------------------------------------
	assign output_request_o = (buf_cnt != '0);
	assign grant = output_permit_i && (buf_cnt != '0);  // empty permit dropped

	always_comb begin
		line = '0;
		line[OUT_NUM_LSB +: READ_NUM_WIDTH]  = res_buf[rd_ptr].read_num;
		line[OUT_K_LSB +: $bits(bwt_idx_t)] = res_buf[rd_ptr].k;
		line[OUT_L_LSB +: $bits(bwt_idx_t)] = res_buf[rd_ptr].l;
	end

	always_ff @(posedge clk_32ui_i) begin
		if (reset_i) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			buf_cnt         <= '0;
			sent_cnt        <= '0;
			output_valid_o  <= 1'b0;
			output_finish_o <= 1'b0;
		end else begin
			output_valid_o  <= grant;
			output_finish_o <= output_valid_o && (sent_cnt == batch_size_i);  // last line out
			if (task_i.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (grant) begin
				rd_ptr   <= rd_ptr + 1'b1;
				sent_cnt <= sent_cnt + 1'b1;
			end
			buf_cnt <= buf_cnt + qcnt_t'(task_i.valid) - qcnt_t'(grant);
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (grant)
			output_data_o <= line;
	end

	a_valid_after_permit: assert property (@(posedge clk_32ui_i) disable iff (reset_i)
		output_valid_o |-> $past(output_permit_i));

endmodule

// ==== rtl/smem_top.sv ====
`timescale 1ns/1ps

module smem_top
	import bwt_pkg::*, io_pkg::*;
(
	input  logic                       clk_32ui_i,
	input  logic                       reset_i,

	// batch load
	input  logic                       load_valid_i,
	input  logic [CL-1:0]              load_data_i,
	input  batch_size_t                batch_size_i,

	// occurrence table requests and responses
	output logic                       dram_valid_o,
	output logic [DRAM_ADDR_WIDTH-1:0] addr_k_o,
	output logic [DRAM_ADDR_WIDTH-1:0] addr_l_o,
	input  logic                       dram_get_i,
	input  logic [31:0]                cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i,
	input  logic [63:0]                cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i,
	input  logic [31:0]                cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i,
	input  logic [63:0]                cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i,

	// result lines
	output logic                       output_request_o,
	input  logic                       output_permit_i,
	output logic [CL-1:0]              output_data_o,
	output logic                       output_valid_o,
	output logic                       output_finish_o
);

	task_if    load_task ();  // loader to queue
	task_if    ext_task ();   // queue to extender
	l2_table_t l2_table;

	read_loader u_read_loader (
		.clk_32ui_i   (clk_32ui_i),
		.reset_i      (reset_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.batch_size_i (batch_size_i),
		.task_o       (load_task),
		.l2_table_o   (l2_table)
	);

	task_queue u_task_queue (
		.clk_32ui_i   (clk_32ui_i),
		.reset_i      (reset_i),
		.task_i       (load_task),
		.dram_valid_o (dram_valid_o),
		.addr_k_o     (addr_k_o),
		.addr_l_o     (addr_l_o),
		.dram_get_i   (dram_get_i),
		.task_o       (ext_task)
	);

	bwt_extender u_bwt_extender (
		.clk_32ui_i       (clk_32ui_i),
		.reset_i          (reset_i),
		.task_i           (ext_task),
		.l2_table_i       (l2_table),
		.batch_size_i     (batch_size_i),
		.cnt_a0_i  (cnt_a0_i),  .cnt_a1_i  (cnt_a1_i),  .cnt_a2_i  (cnt_a2_i),  .cnt_a3_i  (cnt_a3_i),
		.cnt_b0_i  (cnt_b0_i),  .cnt_b1_i  (cnt_b1_i),  .cnt_b2_i  (cnt_b2_i),  .cnt_b3_i  (cnt_b3_i),
		.cntl_a0_i (cntl_a0_i), .cntl_a1_i (cntl_a1_i), .cntl_a2_i (cntl_a2_i), .cntl_a3_i (cntl_a3_i),
		.cntl_b0_i (cntl_b0_i), .cntl_b1_i (cntl_b1_i), .cntl_b2_i (cntl_b2_i), .cntl_b3_i (cntl_b3_i),
		.output_request_o (output_request_o),
		.output_permit_i  (output_permit_i),
		.output_data_o    (output_data_o),
		.output_valid_o   (output_valid_o),
		.output_finish_o  (output_finish_o)
	);

endmodule

// ==== test/tb_smem_top.sv ====
`timescale 1ns/1ps

module tb_smem_top
	import io_pkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int RESET_CYCLES    = 5;
	localparam int DRIVE_DELAY     = 1;
	localparam int RNG_SEED        = 6;
	localparam int MAX_TASKS       = 4;
	localparam int TASK_WORDS      = 25;  // read, k counts, l counts, expected
	localparam int GOLD_WORDS      = 5 + MAX_TASKS * TASK_WORDS;
	localparam int WATCHDOG_MARGIN = 200;

	logic                       clk_32ui_i;
	logic                       reset_i;
	logic                       load_valid_i;
	logic [CL-1:0]              load_data_i;
	batch_size_t                batch_size_i;
	logic                       dram_valid_o;
	logic [DRAM_ADDR_WIDTH-1:0] addr_k_o, addr_l_o;
	logic                       dram_get_i;
	logic [31:0]                cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i;
	logic [63:0]                cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i;
	logic [31:0]                cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i;
	logic [63:0]                cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i;
	logic                       output_request_o, output_permit_i;
	logic [CL-1:0]              output_data_o;
	logic                       output_valid_o, output_finish_o;

	logic [63:0] gold [GOLD_WORDS];
	int          batch;
	int          reqs_seen    = 0;
	int          lines_seen   = 0;
	int          finish_count = 0;
	int          buffered     = 0;     // results waiting in the DUT
	logic        valid_due    = 1'b0;  // a line is owed at the next sample
	logic        finish_due   = 1'b0;

	smem_top DUT (.*);

	always #(CLK_PERIOD / 2) clk_32ui_i = ~clk_32ui_i;

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic end_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [CL-1:0] got,
	                           input logic [CL-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	function automatic int task_base(input int i);
		return 5 + i * TASK_WORDS;
	endfunction

	function automatic logic [CL-1:0] param_line();
		logic [CL-1:0] line;
		line = '0;
		for (int c = 0; c < 4; c++)
			line[64*c +: 64] = gold[1 + c];  // L2 entry per symbol
		return line;
	endfunction

	function automatic logic [CL-1:0] read_line(input int i);
		logic [CL-1:0] line;
		int            b;
		b = task_base(i);
		line = '0;
		line[7:0]     = gold[b][7:0];
		line[9:8]     = gold[b + 1][1:0];
		line[127:64]  = gold[b + 2];
		line[191:128] = gold[b + 3];
		return line;
	endfunction

	function automatic logic [CL-1:0] expected_line(input int i);
		logic [CL-1:0] line;
		int            b;
		b = task_base(i) + 22;
		line = '0;
		line[7:0]     = gold[b][7:0];
		line[127:64]  = gold[b + 1];
		line[191:128] = gold[b + 2];
		return line;
	endfunction

	task automatic drive_counts(input int i);
		int b;
		b = task_base(i) + 4;
		cnt_a0_i  = gold[b][31:0];
		cnt_a1_i  = gold[b + 1][31:0];
		cnt_a2_i  = gold[b + 2][31:0];
		cnt_a3_i  = gold[b + 3][31:0];
		cnt_b0_i  = gold[b + 4];
		cnt_b1_i  = gold[b + 5];
		cnt_b2_i  = gold[b + 6];
		cnt_b3_i  = gold[b + 7];
		cntl_a0_i = gold[b + 8][31:0];
		cntl_a1_i = gold[b + 9][31:0];
		cntl_a2_i = gold[b + 10][31:0];
		cntl_a3_i = gold[b + 11][31:0];
		cntl_b0_i = gold[b + 12];
		cntl_b1_i = gold[b + 13];
		cntl_b2_i = gold[b + 14];
		cntl_b3_i = gold[b + 15];
	endtask

	task automatic send_line(input logic [CL-1:0] data);
		load_valid_i = 1'b1;
		load_data_i  = data;
		@(posedge clk_32ui_i);
		#DRIVE_DELAY;
		load_valid_i = 1'b0;
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		clk_32ui_i      = 1'b0;
		reset_i         = 1'b1;
		load_valid_i    = 1'b0;
		load_data_i     = '0;
		dram_get_i      = 1'b0;
		output_permit_i = 1'b0;
		void'($urandom(RNG_SEED));
		$readmemh("test/golden_ext.txt", gold);
		drive_counts(0);
		batch = int'(gold[0][8:0]);
		if (batch < 1 || batch > MAX_TASKS) begin
			$display("golden file gives batch size %0d, which this testbench cannot run", batch);
			end_with_failure();
		end
		batch_size_i = batch_size_t'(batch);
		repeat (RESET_CYCLES) @(posedge clk_32ui_i);
		#DRIVE_DELAY;
		reset_i = 1'b0;

		repeat (4) begin  // idle before any load
			@(negedge clk_32ui_i);
			check_equal("dram_valid_o", CL'(dram_valid_o), '0);
			check_equal("output_request_o", CL'(output_request_o), '0);
			check_equal("output_valid_o", CL'(output_valid_o), '0);
			check_equal("output_finish_o", CL'(output_finish_o), '0);
		end

		@(posedge clk_32ui_i);
		#DRIVE_DELAY;
		send_line(param_line());
		for (int i = 0; i < batch; i++)
			send_line(read_line(i));
		send_line(read_line(0));  // one line past the batch

		wait (finish_count == 1);
		repeat (10) @(posedge clk_32ui_i);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// ------------------------------------------------------------------
	// DRAM responder and permits
	// ------------------------------------------------------------------
	initial begin
		int gap;
		wait (reset_i === 1'b0);
		for (int i = 0; i < batch; i++) begin
			while (reqs_seen <= i)
				@(posedge clk_32ui_i);
			gap = $urandom % 4;
			repeat (gap) @(posedge clk_32ui_i);
			@(posedge clk_32ui_i);
			#DRIVE_DELAY;
			dram_get_i = 1'b1;
			drive_counts(i);
			@(posedge clk_32ui_i);
			#DRIVE_DELAY;
			dram_get_i = 1'b0;
		end
	end

	// permits also land while nothing is buffered
	initial begin
		int gap;
		wait (reset_i === 1'b0);
		forever begin
			gap = $urandom % 4;
			repeat (gap) @(posedge clk_32ui_i);
			@(posedge clk_32ui_i);
			#DRIVE_DELAY;
			output_permit_i = 1'b1;
			@(posedge clk_32ui_i);
			#DRIVE_DELAY;
			output_permit_i = 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// monitors sampled mid-cycle
	// ------------------------------------------------------------------
	always @(negedge clk_32ui_i) begin
		if (!reset_i && dram_valid_o) begin
			if (reqs_seen >= batch) begin
				$display("the DUT issued more DRAM requests than reads in the batch");
				end_with_failure();
			end
			check_equal("addr_k_o", CL'(addr_k_o), CL'(gold[task_base(reqs_seen) + 20][31:0]));
			check_equal("addr_l_o", CL'(addr_l_o), CL'(gold[task_base(reqs_seen) + 21][31:0]));
			reqs_seen++;
		end
	end

	always @(negedge clk_32ui_i) begin
		if (!reset_i) begin
			check_equal("output_request_o", CL'(output_request_o), CL'(buffered != 0));
			check_equal("output_valid_o", CL'(output_valid_o), CL'(valid_due));
			check_equal("output_finish_o", CL'(output_finish_o), CL'(finish_due));
			valid_due  = output_permit_i && (buffered != 0);  // granted this cycle
			buffered   = buffered + int'(dram_get_i) - int'(valid_due);
			finish_due = 1'b0;
			if (output_finish_o)
				finish_count++;
			if (output_valid_o) begin
				if (lines_seen >= batch) begin
					$display("the DUT sent more output lines than reads in the batch");
					end_with_failure();
				end
				check_equal("output_data_o", output_data_o, expected_line(lines_seen));
				lines_seen++;
				if (lines_seen == batch)
					finish_due = 1'b1;
			end
		end
	end

	// watchdog
	initial begin
		wait (reset_i === 1'b0);
		repeat (batch * 40 + WATCHDOG_MARGIN) @(posedge clk_32ui_i);
		$display("timeout: the batch did not finish within the cycle limit");
		end_with_failure();
	end

endmodule

// ==== test/golden_ext.txt ====
// batch size, then the L2 table entries for A C G T
// per read: num sym k l / k counts a0-a3 b0-b3 / l counts a0-a3 b0-b3 / addr_k addr_l num k l
4 10 200 3000 40000
5 1 183 2a5
7 8 9 a 1 0 0 0
20 30 40 50 5 4 0 0
3 5 5 20a 234
11 0 80 10a
100 0 0 0 0 0 0 0
104 0 0 0 ff 0 0 0
1 2 11 111 11b
2c 3 107f 1140
1 1 1 1000 ffffffffffffffff ffffffffffffffff ffffffffffffffff ffffffffffffffff
0 0 0 2000 c000000000000000 3 3 0
20 22 2c 41080 42003
ff 2 12345678901 123456789ff
0 0 55 0 2 0 0 0
0 0 77 0 0 0 0 aaaaaaaaaaaaaaaa
468acf12 468acf13 ff 3057 3097

// ==== src.f ====
rtl/bwt_pkg.sv
rtl/io_pkg.sv
rtl/task_if.sv
rtl/read_loader.sv
rtl/task_queue.sv
rtl/bwt_extender.sv
rtl/smem_top.sv
test/tb_smem_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_smem_top -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
